//--- bench/tb_vc_link.sv
//////////////////////////////
// Testbench of the two-channel link
// Packet sources with random gaps
// Sinks with random back-pressure
// Per-channel scoreboards checked by assertions
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_vc_link;

  logic                                                clk = 1'b0;
  logic                                                arst_n;
  logic                       [vc_link_pkg::NumVc-1:0] src_valid;
  logic                       [vc_link_pkg::NumVc-1:0] src_head;
  vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0] src_payload;
  logic                       [vc_link_pkg::NumVc-1:0] src_ready;
  logic                       [vc_link_pkg::NumVc-1:0] out_ready;
  logic                       [vc_link_pkg::NumVc-1:0] out_valid;
  logic                       [vc_link_pkg::NumVc-1:0] out_head;
  vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0] out_payload;
  logic                       [vc_link_pkg::NumVc-1:0] out_last;

  // Flit entry {last, head, payload}
  logic [vc_link_pkg::PayloadWidth+1:0] tx_q  [vc_link_pkg::NumVc][$];
  logic [vc_link_pkg::PayloadWidth+1:0] exp_q [vc_link_pkg::NumVc][$];

  // Traffic shape knobs
  int  seed = 7143;
  int  sink_mode = 0;
  bit  src_gaps = 0;
  bit  hold0 = 0;
  bit  fair_check = 0;
  logic [vc_link_pkg::NumVc-1:0] take;

  // Bookkeeping
  int acc_cnt  [vc_link_pkg::NumVc];
  int dlv_cnt  [vc_link_pkg::NumVc];
  int acc_base [vc_link_pkg::NumVc];
  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int test_err_base = 0;
  int flits_total = 0;
  int cycle_limit = 200;
  int cycles = 0;
  string test_name;

  vc_link_top dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .src_valid_i   (src_valid),
    .src_head_i    (src_head),
    .src_payload_i (src_payload),
    .src_ready_o   (src_ready),
    .out_ready_i   (out_ready),
    .out_valid_o   (out_valid),
    .out_head_o    (out_head),
    .out_payload_o (out_payload),
    .out_last_o    (out_last)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic flag_mismatch(input string name, input int vc, input int got, input int want);
    err_cnt++;
    $display("** Error: %s[%0d] = 0x%0h, expected 0x%0h at %0t", name, vc, got, want, $time);
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("Failure: %s at %0t", msg, $time);
  endtask

  // Random body count 0 to 5
  function automatic int pick_length();
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % 6;
  endfunction

  // Head plus len body flits with the last flag set from the length
  task automatic queue_packet(input int v, input int len);
    vc_link_pkg::flit_payload_u p;
    int r;
    r = $random(seed);
    p.head.dst = vc_link_pkg::DstWidth'(r);
    p.head.len = vc_link_pkg::LenWidth'(len);
    tx_q[v].push_back({(len == 0), 1'b1, p});
    for (int i = 1; i <= len; i++) begin
      r = $random(seed);
      p.body = vc_link_pkg::PayloadWidth'(r);
      tx_q[v].push_back({(i == len), 1'b0, p});
    end
    flits_total += len + 1;
    cycle_limit = 4 * flits_total + 200;
  endtask

  function automatic bit traffic_left();
    bit busy;
    busy = (src_valid != '0) || (out_valid != '0);
    for (int v = 0; v < vc_link_pkg::NumVc; v++) begin
      busy = busy || (tx_q[v].size() > 0) || (exp_q[v].size() > 0);
    end
    return busy;
  endfunction

  task automatic drain_all();
    while (traffic_left()) begin
      @(posedge clk);
      #2;
    end
    // Last credit pulses still on their way back
    repeat (3) @(posedge clk);
    #2;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err_base = err_cnt;
    test_cnt++;
  endtask

  task automatic close_test();
    $display("Test %0d %s: %s, %0d errors", test_cnt, test_name,
             (err_cnt == test_err_base) ? "ok" : "failed", err_cnt - test_err_base);
  endtask

  //////////////////////////////
  // Source and sink drivers
  //////////////////////////////

  always @(posedge clk) begin : drive
    int r;
    #1;
    for (int v = 0; v < vc_link_pkg::NumVc; v++) begin
      // Flit taken at this edge leaves the send queue
      if (take[v]) begin
        void'(tx_q[v].pop_front());
        src_valid[v] = 1'b0;
      end
      r = $random(seed);
      if (!src_valid[v] && tx_q[v].size() > 0 && (!src_gaps || r[0])) begin
        src_valid[v]   = 1'b1;
        src_head[v]    = tx_q[v][0][vc_link_pkg::PayloadWidth];
        src_payload[v] = tx_q[v][0][vc_link_pkg::PayloadWidth-1:0];
      end
      // Sink readiness per mode with channel 0 possibly held off
      r = $random(seed);
      case (sink_mode)
        1:       out_ready[v] = r[0];
        2:       out_ready[v] = (r[1:0] == 2'b00);
        default: out_ready[v] = 1'b1;
      endcase
      if (hold0 && v == 0) begin
        out_ready[v] = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Monitor and scoreboards
  //////////////////////////////

  // Mid-cycle sample matches what the next rising edge sees
  always @(negedge clk) begin : monitor
    logic [vc_link_pkg::PayloadWidth+1:0] want;
    int diff;
    if (!arst_n) begin
      take = '0;
      assert (out_valid == '0) else flag_mismatch("out_valid_o", 0, int'(out_valid), 0);
    end else begin
      take = src_valid & src_ready;
      for (int v = 0; v < vc_link_pkg::NumVc; v++) begin
        // Stuck sink gets no grant once its credits are spent
        if (hold0 && v == 0 && acc_cnt[0] - acc_base[0] >= int'(vc_link_pkg::NumCredits)) begin
          assert (!src_ready[0]) else note_failure("channel 0 granted with no credit left");
        end
        if (take[v]) begin
          exp_q[v].push_back(tx_q[v][0]);
          acc_cnt[v]++;
        end
        if (out_valid[v] && out_ready[v]) begin
          check_cnt++;
          assert (exp_q[v].size() > 0) else note_failure("sink got a flit that was never sent");
          if (exp_q[v].size() > 0) begin
            want = exp_q[v].pop_front();
            assert (out_head[v] == want[vc_link_pkg::PayloadWidth])
              else flag_mismatch("out_head_o", v, int'(out_head[v]),
                                 int'(want[vc_link_pkg::PayloadWidth]));
            assert (out_payload[v] == want[vc_link_pkg::PayloadWidth-1:0])
              else flag_mismatch("out_payload_o", v, int'(out_payload[v]),
                                 int'(want[vc_link_pkg::PayloadWidth-1:0]));
            assert (out_last[v] == want[vc_link_pkg::PayloadWidth+1])
              else flag_mismatch("out_last_o", v, int'(out_last[v]),
                                 int'(want[vc_link_pkg::PayloadWidth+1]));
          end
          dlv_cnt[v]++;
        end
        assert (acc_cnt[v] - dlv_cnt[v] <= int'(vc_link_pkg::NumCredits))
          else note_failure("more flits in flight than credits allow");
      end
      // Shares stay close while both sources are busy
      if (fair_check && tx_q[0].size() > 0 && tx_q[1].size() > 0) begin
        diff = (acc_cnt[0] - acc_base[0]) - (acc_cnt[1] - acc_base[1]);
        assert (diff <= int'(vc_link_pkg::NumCredits) && diff >= -int'(vc_link_pkg::NumCredits))
          else note_failure("round robin let one channel run ahead");
      end
    end
  end

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin : watchdog
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, traffic never drained", cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    arst_n      = 1'b0;
    src_valid   = '0;
    src_head    = '0;
    src_payload = '0;
    out_ready   = '0;
    take        = '0;
    for (int v = 0; v < vc_link_pkg::NumVc; v++) begin
      acc_cnt[v]  = 0;
      dlv_cnt[v]  = 0;
      acc_base[v] = 0;
    end

    // Reset state with credits full on release
    start_test("reset state");
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    @(negedge clk);
    assert (out_valid == '0) else flag_mismatch("out_valid_o", 0, int'(out_valid), 0);
    for (int v = 0; v < vc_link_pkg::NumVc; v++) begin
      queue_packet(v, 0);
      @(negedge clk);
      while (!src_valid[v]) @(negedge clk);
      assert (src_ready[v]) else note_failure("first flit after reset was refused");
      drain_all();
    end
    close_test();

    // Ordering under random back-pressure and source gaps
    start_test("ordering and integrity");
    sink_mode = 1;
    src_gaps  = 1;
    for (int i = 0; i < 8; i++) begin
      queue_packet(0, pick_length());
      queue_packet(1, pick_length());
    end
    drain_all();
    close_test();

    // Packet ends with short and long lengths
    start_test("packet boundaries");
    sink_mode = 0;
    queue_packet(0, 0);
    queue_packet(0, 5);
    queue_packet(0, 1);
    queue_packet(1, 5);
    queue_packet(1, 0);
    queue_packet(1, 2);
    drain_all();
    close_test();

    // Slow sinks keep the credit bound busy
    start_test("credit bound");
    sink_mode = 2;
    src_gaps  = 0;
    for (int i = 0; i < 6; i++) begin
      queue_packet(0, pick_length());
      queue_packet(1, pick_length());
    end
    drain_all();
    close_test();

    // Channel 1 runs through while channel 0 is stuck
    start_test("channel independence");
    sink_mode = 0;
    hold0     = 1'b1;
    acc_base  = acc_cnt;
    for (int i = 0; i < 3; i++) begin
      queue_packet(0, 3);
    end
    for (int i = 0; i < 6; i++) begin
      queue_packet(1, pick_length());
    end
    while (tx_q[1].size() > 0 || exp_q[1].size() > 0) begin
      @(posedge clk);
      #2;
    end
    assert (acc_cnt[0] - acc_base[0] == int'(vc_link_pkg::NumCredits))
      else flag_mismatch("src_ready_o accepted count", 0, acc_cnt[0] - acc_base[0],
                         int'(vc_link_pkg::NumCredits));
    hold0 = 1'b0;
    drain_all();
    close_test();

    // Both sides saturated
    start_test("fairness");
    acc_base   = acc_cnt;
    fair_check = 1'b1;
    for (int i = 0; i < 8; i++) begin
      queue_packet(0, pick_length());
      queue_packet(1, pick_length());
    end
    drain_all();
    fair_check = 1'b0;
    close_test();

    $display("Tests %0d, transfers checked %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the two-channel link testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vc_link.f --top-module tb_vc_link -o tb_vc_link
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_vc_link)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

//--- src/vc_link_arbiter.sv
//////////////////////////////
// Sender side of the link
// Per-channel credit counters
// Round-robin pick of one channel per cycle
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vc_link_arbiter (
  input  wire logic                                                    clk_i,
  input  wire logic                                                    arst_n_i,
  // Virtual channel sources
  input  wire logic                  [vc_link_pkg::NumVc-1:0]          src_valid_i,
  input  wire logic                  [vc_link_pkg::NumVc-1:0]          src_head_i,
  input  wire vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0]     src_payload_i,
  output logic                       [vc_link_pkg::NumVc-1:0]          src_ready_o,
  // Credit return from the receiver
  input  wire logic                  [vc_link_pkg::NumVc-1:0]          credit_i,
  // Physical link
  output logic                                                         link_valid_o,
  output logic                       [vc_link_pkg::VcWidth-1:0]        link_vc_o,
  output logic                                                         link_head_o,
  output vc_link_pkg::flit_payload_u                                   link_payload_o
);

  //////////////////////////////
  // State
  //////////////////////////////

  // Credits left per channel
  logic [vc_link_pkg::CreditWidth-1:0] credit_q [vc_link_pkg::NumVc];
  // Channel that wins a tie next
  logic [vc_link_pkg::VcWidth-1:0]     rr_q;

  logic [vc_link_pkg::NumVc-1:0]       credit_left;
  logic [vc_link_pkg::NumVc-1:0]       req;
  logic [vc_link_pkg::VcWidth-1:0]     gnt_idx;

  //////////////////////////////
  // Request masking and grant
  //////////////////////////////

  // A channel only competes with a credit in hand
  always_comb begin
    for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
      credit_left[v] = (credit_q[v] != '0);
    end
  end

  assign req = src_valid_i & credit_left;

  // Priority channel first, otherwise the other one
  always_comb begin
    gnt_idx = req[rr_q] ? rr_q : ~rr_q;
  end

  // Grant goes back to the winner as its ready
  always_comb begin
    link_valid_o = |req;
    src_ready_o  = '0;
    if (link_valid_o) begin
      src_ready_o[gnt_idx] = 1'b1;
    end
  end

  // Winner's flit onto the shared link
  assign link_vc_o      = gnt_idx;
  assign link_head_o    = src_head_i[gnt_idx];
  assign link_payload_o = src_payload_i[gnt_idx];

  //////////////////////////////
  // Priority and credit update
  //////////////////////////////

  // Priority hands over to the loser after every grant
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= '0;
    end else if (link_valid_o) begin
      rr_q <= ~gnt_idx;
    end
  end

  // Returned credit and grant may land in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
        credit_q[v] <= vc_link_pkg::CreditWidth'(vc_link_pkg::NumCredits);
      end
    end else begin
      for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
        credit_q[v] <= credit_q[v]
                     + vc_link_pkg::CreditWidth'(credit_i[v])
                     - vc_link_pkg::CreditWidth'(src_ready_o[v]);
      end
    end
  end

endmodule

`default_nettype wire

//--- src/vc_link_pkg.sv
//////////////////////////////
// Shared constants of the two-channel link
// Channel count, credit depth, field widths
// Flit payload union with head and body views
//////////////////////////////

`default_nettype none

package vc_link_pkg;

  //////////////////////////////
  // Link sizing
  //////////////////////////////

  // Virtual channels sharing the physical link
  localparam int unsigned NumVc = 2;
  // Credits per channel, equal to buffer depth per channel
  localparam int unsigned NumCredits = 4;
  // Counter must reach NumCredits itself
  localparam int unsigned CreditWidth = $clog2(NumCredits + 1);
  // FIFO pointer width
  localparam int unsigned PtrWidth = $clog2(NumCredits);
  // Channel index on the link
  localparam int unsigned VcWidth = $clog2(NumVc);

  //////////////////////////////
  // Flit format
  //////////////////////////////

  localparam int unsigned PayloadWidth = 16;
  // Head fields, destination in the upper bits
  localparam int unsigned DstWidth = 12;
  localparam int unsigned LenWidth = 4;

  // One payload word, two readings
  // Head bit beside the payload picks the view
  typedef union packed {
    struct packed {
      logic [DstWidth-1:0] dst;
      // Number of body flits after this head
      logic [LenWidth-1:0] len;
    } head;
    logic [PayloadWidth-1:0] body;
  } flit_payload_u;

endpackage

`default_nettype wire

//--- src/vc_link_top.sv
//////////////////////////////
// Two-channel link top level
// Arbiter, input buffer, drain
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vc_link_top (
  input  wire logic                                                clk_i,
  input  wire logic                                                arst_n_i,
  // Sources
  input  wire logic                  [vc_link_pkg::NumVc-1:0]      src_valid_i,
  input  wire logic                  [vc_link_pkg::NumVc-1:0]      src_head_i,
  input  wire vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0] src_payload_i,
  output logic                       [vc_link_pkg::NumVc-1:0]      src_ready_o,
  // Sinks
  input  wire logic                  [vc_link_pkg::NumVc-1:0]      out_ready_i,
  output logic                       [vc_link_pkg::NumVc-1:0]      out_valid_o,
  output logic                       [vc_link_pkg::NumVc-1:0]      out_head_o,
  output vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0]      out_payload_o,
  output logic                       [vc_link_pkg::NumVc-1:0]      out_last_o
);

  // Physical link, valid only, no ready
  logic                                                 link_valid;
  logic                       [vc_link_pkg::VcWidth-1:0] link_vc;
  logic                                                 link_head;
  vc_link_pkg::flit_payload_u                           link_payload;

  // Buffer to drain
  logic                       [vc_link_pkg::NumVc-1:0] buf_valid;
  logic                       [vc_link_pkg::NumVc-1:0] buf_head;
  vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0] buf_payload;
  logic                       [vc_link_pkg::NumVc-1:0] buf_pop;

  // Credit return path
  logic                       [vc_link_pkg::NumVc-1:0] credit;

  vc_link_arbiter u_arbiter (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .src_valid_i    (src_valid_i),
    .src_head_i     (src_head_i),
    .src_payload_i  (src_payload_i),
    .src_ready_o    (src_ready_o),
    .credit_i       (credit),
    .link_valid_o   (link_valid),
    .link_vc_o      (link_vc),
    .link_head_o    (link_head),
    .link_payload_o (link_payload)
  );

  vc_rx_buffer u_buffer (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .link_valid_i   (link_valid),
    .link_vc_i      (link_vc),
    .link_head_i    (link_head),
    .link_payload_i (link_payload),
    .pop_i          (buf_pop),
    .valid_o        (buf_valid),
    .head_o         (buf_head),
    .payload_o      (buf_payload)
  );

  vc_rx_drain u_drain (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .buf_valid_i    (buf_valid),
    .buf_head_i     (buf_head),
    .buf_payload_i  (buf_payload),
    .buf_pop_o      (buf_pop),
    .out_ready_i    (out_ready_i),
    .out_valid_o    (out_valid_o),
    .out_head_o     (out_head_o),
    .out_payload_o  (out_payload_o),
    .out_last_o     (out_last_o),
    .credit_o       (credit)
  );

endmodule

`default_nettype wire

//--- src/vc_rx_buffer.sv
//////////////////////////////
// Receiver input buffer
// One circular FIFO per virtual channel
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vc_rx_buffer (
  input  wire logic                                                clk_i,
  input  wire logic                                                arst_n_i,
  // Link from the sender
  input  wire logic                                                link_valid_i,
  input  wire logic                  [vc_link_pkg::VcWidth-1:0]    link_vc_i,
  input  wire logic                                                link_head_i,
  input  wire vc_link_pkg::flit_payload_u                          link_payload_i,
  // Per-channel pop from the drain
  input  wire logic                  [vc_link_pkg::NumVc-1:0]      pop_i,
  // FIFO heads
  output logic                       [vc_link_pkg::NumVc-1:0]      valid_o,
  output logic                       [vc_link_pkg::NumVc-1:0]      head_o,
  output vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0]      payload_o
);

  // Flit storage
  vc_link_pkg::flit_payload_u payload_mem [vc_link_pkg::NumVc][vc_link_pkg::NumCredits];
  logic                       head_mem    [vc_link_pkg::NumVc][vc_link_pkg::NumCredits];

  // Pointers and fill level per channel
  logic [vc_link_pkg::PtrWidth-1:0]    wr_ptr_q [vc_link_pkg::NumVc];
  logic [vc_link_pkg::PtrWidth-1:0]    rd_ptr_q [vc_link_pkg::NumVc];
  logic [vc_link_pkg::CreditWidth-1:0] count_q  [vc_link_pkg::NumVc];

  logic [vc_link_pkg::NumVc-1:0]       wr_en;

  //////////////////////////////
  // Write side
  //////////////////////////////

  // Link channel index picks the FIFO
  // Credits keep each FIFO's fill level within its depth
  always_comb begin
    wr_en = '0;
    if (link_valid_i) begin
      wr_en[link_vc_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (link_valid_i) begin
      payload_mem[link_vc_i][wr_ptr_q[link_vc_i]] <= link_payload_i;
      head_mem[link_vc_i][wr_ptr_q[link_vc_i]]    <= link_head_i;
    end
  end

  //////////////////////////////
  // Pointer bookkeeping
  //////////////////////////////

  // Pointers wrap at the power-of-two depth
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
        wr_ptr_q[v] <= '0;
        rd_ptr_q[v] <= '0;
        count_q[v]  <= '0;
      end
    end else begin
      for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
        if (wr_en[v]) begin
          wr_ptr_q[v] <= wr_ptr_q[v] + vc_link_pkg::PtrWidth'(1);
        end
        if (pop_i[v]) begin
          rd_ptr_q[v] <= rd_ptr_q[v] + vc_link_pkg::PtrWidth'(1);
        end
        count_q[v] <= count_q[v]
                    + vc_link_pkg::CreditWidth'(wr_en[v])
                    - vc_link_pkg::CreditWidth'(pop_i[v]);
      end
    end
  end

  // FIFO head appears one cycle after the write
  always_comb begin
    for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
      valid_o[v]   = (count_q[v] != '0);
      head_o[v]    = head_mem[v][rd_ptr_q[v]];
      payload_o[v] = payload_mem[v][rd_ptr_q[v]];
    end
  end

endmodule

`default_nettype wire

//--- src/vc_rx_drain.sv
//////////////////////////////
// Receiver drain stage
// Hands flits to the sinks and returns credits
// Tracks packet ends from head lengths
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vc_rx_drain (
  input  wire logic                                                clk_i,
  input  wire logic                                                arst_n_i,
  // FIFO heads from the buffer
  input  wire logic                  [vc_link_pkg::NumVc-1:0]      buf_valid_i,
  input  wire logic                  [vc_link_pkg::NumVc-1:0]      buf_head_i,
  input  wire vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0] buf_payload_i,
  output logic                       [vc_link_pkg::NumVc-1:0]      buf_pop_o,
  // Sinks
  input  wire logic                  [vc_link_pkg::NumVc-1:0]      out_ready_i,
  output logic                       [vc_link_pkg::NumVc-1:0]      out_valid_o,
  output logic                       [vc_link_pkg::NumVc-1:0]      out_head_o,
  output vc_link_pkg::flit_payload_u [vc_link_pkg::NumVc-1:0]      out_payload_o,
  output logic                       [vc_link_pkg::NumVc-1:0]      out_last_o,
  // Credit pulses toward the sender
  output logic                       [vc_link_pkg::NumVc-1:0]      credit_o
);

  // Registered pop returns one credit per flit
  logic [vc_link_pkg::NumVc-1:0]    credit_q;
  // Body flits still expected in the current packet
  logic [vc_link_pkg::LenWidth-1:0] remain_q [vc_link_pkg::NumVc];

  //////////////////////////////
  // Sink handshake
  //////////////////////////////

  // Sink outputs come straight from the FIFO head
  assign out_valid_o   = buf_valid_i;
  assign out_head_o    = buf_head_i;
  assign out_payload_o = buf_payload_i;
  assign buf_pop_o     = buf_valid_i & out_ready_i;

  // Last flit flag
  // A zero-length head ends its packet at once
  // Otherwise the body flit with one remaining ends it
  always_comb begin
    for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
      if (buf_head_i[v]) begin
        out_last_o[v] = (buf_payload_i[v].head.len == '0);
      end else begin
        out_last_o[v] = (remain_q[v] == vc_link_pkg::LenWidth'(1));
      end
    end
  end

  //////////////////////////////
  // Credits and packet tracking
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q <= '0;
      for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
        remain_q[v] <= '0;
      end
    end else begin
      credit_q <= buf_pop_o;
      for (int unsigned v = 0; v < vc_link_pkg::NumVc; v++) begin
        if (buf_pop_o[v]) begin
          // Head loads the body count
          if (buf_head_i[v]) begin
            remain_q[v] <= buf_payload_i[v].head.len;
          end else if (remain_q[v] != '0) begin
            remain_q[v] <= remain_q[v] - vc_link_pkg::LenWidth'(1);
          end
        end
      end
    end
  end

  assign credit_o = credit_q;

endmodule

`default_nettype wire

//--- vc_link.f
src/vc_link_pkg.sv
src/vc_link_arbiter.sv
src/vc_rx_buffer.sv
src/vc_rx_drain.sv
src/vc_link_top.sv
bench/tb_vc_link.sv
